// File: include/rv32_defs.svh
// ##########################################################################
// RV32I core widths, major opcodes and program counter reset address
// ##########################################################################

`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// Datapath and register index widths
`define RV32_XLEN        32
`define RV32_REG_AW      5

// PC value after reset
`define RV32_RESET_ADDR  32'h0000_0000

// Major opcodes, insn[6:0]
`define RV32_OP_LUI      7'b0110111
`define RV32_OP_AUIPC    7'b0010111
`define RV32_OP_JAL      7'b1101111
`define RV32_OP_JALR     7'b1100111
`define RV32_OP_BRANCH   7'b1100011
`define RV32_OP_LOAD     7'b0000011
`define RV32_OP_STORE    7'b0100011
`define RV32_OP_IMM      7'b0010011
`define RV32_OP_REG      7'b0110011

`endif

// File: source/rv32_pkg.sv
// ##########################################################################
// RV32I core types passed between the stages and out of the core
// ##########################################################################

`include "rv32_defs.svh"

package rv32_pkg;

	typedef logic [`RV32_XLEN-1:0]   xlen_t;
	typedef logic [`RV32_REG_AW-1:0] reg_addr_t;

	// Register file request group, request set only for a used nonzero index
	typedef struct packed {
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		reg_addr_t rd_addr;
		logic      rs1_request;
		logic      rs2_request;
		logic      rd_request;
	} reg_req_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,   // LUI and store data
		ALU_AUIPC
	} alu_op_t;

	typedef struct packed {
		alu_op_t  alu_op;
		logic     uses_imm;    // Operand B from imm instead of rs2
		xlen_t    imm;
		logic     is_branch;
		logic     [2:0] funct3;
		logic     is_jal;
		logic     is_jalr;
		logic     is_load;
		logic     is_store;
		logic     legal;
		reg_req_t regs;
	} decoded_t;

	typedef struct packed {
		xlen_t      alu;        // Also carries rs2 for stores
		xlen_t      link;       // pc+4
		xlen_t      pc_next;
		xlen_t      mem_addr;
		logic       is_link;    // JAL or JALR writes the link value
		logic       is_load;
		logic       is_store;
		logic [2:0] funct3;
	} exec_t;

	typedef struct packed {
		logic       valid;
		xlen_t      addr;
		xlen_t      wdata;
		logic [3:0] wstrb;
		logic [3:0] rmask;
	} mem_req_t;

endpackage

// File: source/rv32_pc_sequencer.sv
// ##########################################################################
// Program counter register, instruction completion and trap lock
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_pc_sequencer import rv32_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     insn_valid,
	input  logic     legal,
	input  reg_req_t regs,
	input  logic     mem_valid,
	input  logic     rs1_ready,
	input  logic     rs2_ready,
	input  logic     rd_ready,
	input  logic     mem_ready,
	input  xlen_t    pc_next,
	output xlen_t    pc,
	output logic     insn_complete,
	output logic     trap
);

	logic rs1_ok;
	logic rs2_ok;
	logic rd_ok;
	logic mem_ok;

	// A ready level only counts while its request is up
	assign rs1_ok = !regs.rs1_request || rs1_ready;
	assign rs2_ok = !regs.rs2_request || rs2_ready;
	assign rd_ok  = !regs.rd_request  || rd_ready;
	assign mem_ok = !mem_valid        || mem_ready;

	assign insn_complete = insn_valid && rs1_ok && rs2_ok && rd_ok && mem_ok;
	assign trap          = insn_valid && !legal;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RV32_RESET_ADDR;
		end else if (insn_complete && !trap) begin
			pc <= pc_next;   // Held for good once a trap shows up
		end
	end

endmodule

// File: source/rv32_decode.sv
// ##########################################################################
// RV32I decode: fields, immediates, legality, ALU op and register requests
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_decode import rv32_pkg::*; (
	input  xlen_t    insn,
	input  logic     insn_valid,
	output decoded_t dec,
	output reg_req_t regs
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	reg_addr_t  rs1;
	reg_addr_t  rs2;

	xlen_t imm_i;
	xlen_t imm_s;
	xlen_t imm_b;
	xlen_t imm_u;
	xlen_t imm_j;

	logic    op_imm;
	logic    legal;
	logic    ok;
	logic    rs1_used;
	logic    rs2_used;
	logic    rd_used;
	logic    uses_imm;
	xlen_t   imm;
	alu_op_t alu_op;
	logic    is_branch;
	logic    is_jal;
	logic    is_jalr;
	logic    is_load;
	logic    is_store;

	assign opcode = insn[6:0];
	assign rd     = insn[11:7];
	assign funct3 = insn[14:12];
	assign rs1    = insn[19:15];
	assign rs2    = insn[24:20];
	assign funct7 = insn[31:25];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	assign op_imm = (opcode == `RV32_OP_IMM);

	always_comb begin
		legal     = 1'b0;
		rs1_used  = 1'b0;
		rs2_used  = 1'b0;
		rd_used   = 1'b0;
		uses_imm  = 1'b0;
		imm       = imm_i;
		alu_op    = ALU_ADD;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		case (opcode)
			`RV32_OP_LUI: begin
				legal    = 1'b1;
				rd_used  = 1'b1;
				uses_imm = 1'b1;
				imm      = imm_u;
				alu_op   = ALU_PASS_B;
			end
			`RV32_OP_AUIPC: begin
				legal   = 1'b1;
				rd_used = 1'b1;
				imm     = imm_u;
				alu_op  = ALU_AUIPC;
			end
			`RV32_OP_JAL: begin
				legal   = 1'b1;
				rd_used = 1'b1;
				imm     = imm_j;
				is_jal  = 1'b1;
			end
			`RV32_OP_JALR: begin
				legal    = (funct3 == 3'b000);
				rs1_used = 1'b1;
				rd_used  = 1'b1;
				is_jalr  = 1'b1;
			end
			`RV32_OP_BRANCH: begin
				legal     = (funct3 != 3'b010) && (funct3 != 3'b011);
				rs1_used  = 1'b1;
				rs2_used  = 1'b1;
				imm       = imm_b;
				is_branch = 1'b1;
			end
			`RV32_OP_LOAD: begin
				legal    = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				rs1_used = 1'b1;
				rd_used  = 1'b1;
				is_load  = 1'b1;
			end
			`RV32_OP_STORE: begin
				legal    = funct3 inside {3'b000, 3'b001, 3'b010};
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm      = imm_s;
				alu_op   = ALU_PASS_B;   // rs2 rides the ALU out as store data
				is_store = 1'b1;
			end
			`RV32_OP_IMM, `RV32_OP_REG: begin
				rs1_used = 1'b1;
				rs2_used = !op_imm;
				rd_used  = 1'b1;
				uses_imm = op_imm;
				case (funct3)
					3'b000:  alu_op = (!op_imm && funct7[5]) ? ALU_SUB : ALU_ADD;
					3'b001:  alu_op = ALU_SLL;
					3'b010:  alu_op = ALU_SLT;
					3'b011:  alu_op = ALU_SLTU;
					3'b100:  alu_op = ALU_XOR;
					3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
					3'b110:  alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
				// Shifts check funct7 in both forms, the rest only for OP
				if (funct3 == 3'b001)
					legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101 || (!op_imm && funct3 == 3'b000))
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				else
					legal = op_imm || (funct7 == 7'b0000000);
			end
			default: ;
		endcase
	end

	assign ok = insn_valid && legal;

	always_comb begin
		regs.rs1_addr    = (ok && rs1_used) ? rs1 : '0;   // Unused index reads as x0
		regs.rs2_addr    = (ok && rs2_used) ? rs2 : '0;
		regs.rd_addr     = (ok && rd_used)  ? rd  : '0;
		regs.rs1_request = ok && rs1_used && (rs1 != '0);
		regs.rs2_request = ok && rs2_used && (rs2 != '0);
		regs.rd_request  = ok && rd_used  && (rd  != '0);

		dec.alu_op    = alu_op;
		dec.uses_imm  = uses_imm;
		dec.imm       = imm;
		dec.is_branch = ok && is_branch;
		dec.funct3    = funct3;
		dec.is_jal    = ok && is_jal;
		dec.is_jalr   = ok && is_jalr;
		dec.is_load   = ok && is_load;
		dec.is_store  = ok && is_store;
		dec.legal     = ok;
		dec.regs      = regs;
	end

endmodule

// File: source/rv32_execute.sv
// ##########################################################################
// RV32I execute: ALU, branch compare, next PC and load/store address
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_execute import rv32_pkg::*; (
	input  decoded_t dec,
	input  xlen_t    rs1_rdata,
	input  xlen_t    rs2_rdata,
	input  xlen_t    pc,
	output exec_t    ex
);

	xlen_t      rs1_val;
	xlen_t      rs2_val;
	xlen_t      op_b;
	xlen_t      addr_sum;
	xlen_t      pc_plus4;
	xlen_t      pc_rel;
	xlen_t      alu_res;
	xlen_t      next_pc;
	logic [4:0] shamt;
	logic       lt;
	logic       ltu;
	logic       taken;

	// x0 is hardwired to zero whatever the register file returns
	assign rs1_val = (dec.regs.rs1_addr == '0) ? '0 : rs1_rdata;
	assign rs2_val = (dec.regs.rs2_addr == '0) ? '0 : rs2_rdata;

	// Branches never take the immediate, so op_b is rs2 for them
	assign op_b  = dec.uses_imm ? dec.imm : rs2_val;
	assign shamt = op_b[4:0];

	// Signed compare by flipping the sign bits
	assign lt  = {~rs1_val[`RV32_XLEN-1], rs1_val[`RV32_XLEN-2:0]} <
	             {~op_b[`RV32_XLEN-1], op_b[`RV32_XLEN-2:0]};
	assign ltu = rs1_val < op_b;

	assign addr_sum = rs1_val + dec.imm;   // Load/store address and JALR target
	assign pc_plus4 = pc + 32'd4;
	assign pc_rel   = pc + dec.imm;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    alu_res = rs1_val + op_b;
			ALU_SUB:    alu_res = rs1_val - op_b;
			ALU_SLL:    alu_res = rs1_val << shamt;
			ALU_SLT:    alu_res = {31'b0, lt};
			ALU_SLTU:   alu_res = {31'b0, ltu};
			ALU_XOR:    alu_res = rs1_val ^ op_b;
			ALU_SRL:    alu_res = rs1_val >> shamt;
			ALU_SRA:    alu_res = $signed(rs1_val) >>> shamt;
			ALU_OR:     alu_res = rs1_val | op_b;
			ALU_AND:    alu_res = rs1_val & op_b;
			ALU_PASS_B: alu_res = op_b;
			ALU_AUIPC:  alu_res = pc_rel;
			default:    alu_res = '0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000:  taken = (rs1_val == rs2_val);   // BEQ
			3'b001:  taken = (rs1_val != rs2_val);   // BNE
			3'b100:  taken = lt;                     // BLT
			3'b101:  taken = !lt;                    // BGE
			3'b110:  taken = ltu;                    // BLTU
			3'b111:  taken = !ltu;                   // BGEU
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec.is_jalr)
			next_pc = {addr_sum[`RV32_XLEN-1:1], 1'b0};
		else if (dec.is_jal || (dec.is_branch && taken))
			next_pc = pc_rel;
		else
			next_pc = pc_plus4;
	end

	always_comb begin
		ex.alu      = alu_res;
		ex.link     = pc_plus4;
		ex.pc_next  = next_pc;
		ex.mem_addr = addr_sum;
		ex.is_link  = dec.is_jal || dec.is_jalr;
		ex.is_load  = dec.is_load;
		ex.is_store = dec.is_store;
		ex.funct3   = dec.funct3;
	end

endmodule

// File: source/rv32_mem_access.sv
// ##########################################################################
// Data memory request, load extension and write-back select
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_mem_access import rv32_pkg::*; (
	input  exec_t    ex,
	input  xlen_t    mem_rdata,
	output mem_req_t mem,
	output xlen_t    rd_wdata
);

	logic [3:0] size_mask;
	xlen_t      load_data;

	// Byte lanes by access size, no lane shifting
	always_comb begin
		case (ex.funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		case (ex.funct3)
			3'b000:  load_data = {{(`RV32_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};     // LB
			3'b001:  load_data = {{(`RV32_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};  // LH
			3'b100:  load_data = {{(`RV32_XLEN-8){1'b0}}, mem_rdata[7:0]};             // LBU
			3'b101:  load_data = {{(`RV32_XLEN-16){1'b0}}, mem_rdata[15:0]};           // LHU
			default: load_data = mem_rdata;                                              // LW
		endcase
	end

	always_comb begin
		mem.valid = ex.is_load || ex.is_store;
		mem.addr  = mem.valid   ? ex.mem_addr : '0;
		mem.wdata = ex.is_store ? ex.alu      : '0;   // rs2 as passed by the ALU
		mem.wstrb = ex.is_store ? size_mask   : 4'b0000;
		mem.rmask = ex.is_load  ? size_mask   : 4'b0000;
	end

	always_comb begin
		if (ex.is_load)
			rd_wdata = load_data;
		else if (ex.is_link)
			rd_wdata = ex.link;
		else
			rd_wdata = ex.alu;
	end

endmodule

// File: source/rv32_core.sv
// ##########################################################################
// Single-cycle RV32I core, decode to execute to memory with a PC register
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module rv32_core import rv32_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  xlen_t    insn,
	input  logic     insn_valid,
	input  xlen_t    rs1_rdata,
	input  xlen_t    rs2_rdata,
	input  logic     rs1_ready,
	input  logic     rs2_ready,
	input  logic     rd_ready,
	input  xlen_t    mem_rdata,
	input  logic     mem_ready,
	output xlen_t    insn_addr,
	output logic     insn_complete,
	output logic     trap,
	output reg_req_t regs,
	output xlen_t    rd_wdata,
	output mem_req_t mem
);

	decoded_t dec;
	exec_t    ex;
	xlen_t    pc;

	assign insn_addr = pc;   // Fetch address is the current PC

	rv32_pc_sequencer u_pc_sequencer (
		.clk           (clk),
		.reset         (reset),
		.insn_valid    (insn_valid),
		.legal         (dec.legal),
		.regs          (regs),
		.mem_valid     (mem.valid),
		.rs1_ready     (rs1_ready),
		.rs2_ready     (rs2_ready),
		.rd_ready      (rd_ready),
		.mem_ready     (mem_ready),
		.pc_next       (ex.pc_next),
		.pc            (pc),
		.insn_complete (insn_complete),
		.trap          (trap)
	);

	rv32_decode u_decode (
		.insn       (insn),
		.insn_valid (insn_valid),
		.dec        (dec),
		.regs       (regs)
	);

	rv32_execute u_execute (
		.dec       (dec),
		.rs1_rdata (rs1_rdata),
		.rs2_rdata (rs2_rdata),
		.pc        (pc),
		.ex        (ex)
	);

	rv32_mem_access u_mem_access (
		.ex        (ex),
		.mem_rdata (mem_rdata),
		.mem       (mem),
		.rd_wdata  (rd_wdata)
	);

endmodule

// File: testbench/tb_rv32_core.sv
// ##########################################################################
// Testbench for the RV32I core with register, memory and reference PC models
// ##########################################################################

`timescale 1ns/1ps

`include "rv32_defs.svh"

module tb_rv32_core import rv32_pkg::*; ();

	logic       clk;
	logic       reset;
	xlen_t      insn;
	logic       insn_valid;
	xlen_t      rs1_rdata;
	xlen_t      rs2_rdata;
	logic       rs1_ready;
	logic       rs2_ready;
	logic       rd_ready;
	xlen_t      mem_rdata;
	logic       mem_ready;
	xlen_t      insn_addr;
	logic       insn_complete;
	logic       trap;
	reg_req_t   regs;
	xlen_t      rd_wdata;
	mem_req_t   mem;

	xlen_t       rng;
	xlen_t       reg_vals [0:31];   // Register file model, x0 slot holds junk on purpose
	xlen_t       model_pc;
	xlen_t       exp_next;
	xlen_t       exp_wdata;
	logic        chk_wdata;
	logic        exp_legal;
	logic [2:0]  exp_req;           // rs1, rs2, rd
	logic [14:0] exp_addr;          // rs1, rs2, rd indices
	mem_req_t    exp_mem;
	logic        exp_complete;
	logic        exp_trap;
	int          err_count;
	int          other_count;
	int          insn_count;

	rv32_core u_rv32_core (
		.clk           (clk),
		.reset         (reset),
		.insn          (insn),
		.insn_valid    (insn_valid),
		.rs1_rdata     (rs1_rdata),
		.rs2_rdata     (rs2_rdata),
		.rs1_ready     (rs1_ready),
		.rs2_ready     (rs2_ready),
		.rd_ready      (rd_ready),
		.mem_rdata     (mem_rdata),
		.mem_ready     (mem_ready),
		.insn_addr     (insn_addr),
		.insn_complete (insn_complete),
		.trap          (trap),
		.regs          (regs),
		.rd_wdata      (rd_wdata),
		.mem           (mem)
	);

	always #10 clk = ~clk;

	// Completion and trap follow the level rules from the expected requests
	assign exp_complete = insn_valid && (!exp_req[2] || rs1_ready) && (!exp_req[1] || rs2_ready)
		&& (!exp_req[0] || rd_ready) && (!exp_mem.valid || mem_ready);
	assign exp_trap = insn_valid && !exp_legal;

	always @(posedge clk) begin
		if (reset)
			model_pc <= `RV32_RESET_ADDR;
		else if (exp_complete && !exp_trap)
			model_pc <= exp_next;
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		$display("mismatch at time %0t: %s got %0h, expected %0h", $time, name, got, expected);
		err_count++;
	endtask

	assert property (@(posedge clk) disable iff (reset) insn_addr == model_pc)
		else report_mismatch("insn_addr", 128'($sampled(insn_addr)), 128'($sampled(model_pc)));
	assert property (@(posedge clk) disable iff (reset) insn_complete == exp_complete)
		else report_mismatch("insn_complete", 128'($sampled(insn_complete)),
			128'($sampled(exp_complete)));
	assert property (@(posedge clk) disable iff (reset) trap == exp_trap)
		else report_mismatch("trap", 128'($sampled(trap)), 128'($sampled(exp_trap)));
	assert property (@(posedge clk) disable iff (reset)
		{regs.rs1_request, regs.rs2_request, regs.rd_request} == exp_req)
		else report_mismatch("regs requests",
			128'($sampled({regs.rs1_request, regs.rs2_request, regs.rd_request})),
			128'($sampled(exp_req)));
	assert property (@(posedge clk) disable iff (reset)
		(!exp_req[2] || regs.rs1_addr == exp_addr[14:10])
		&& (!exp_req[1] || regs.rs2_addr == exp_addr[9:5])
		&& (!exp_req[0] || regs.rd_addr == exp_addr[4:0]))
		else report_mismatch("regs addresses",
			128'($sampled({regs.rs1_addr, regs.rs2_addr, regs.rd_addr})),
			128'($sampled(exp_addr)));
	assert property (@(posedge clk) disable iff (reset) chk_wdata |-> rd_wdata == exp_wdata)
		else report_mismatch("rd_wdata", 128'($sampled(rd_wdata)), 128'($sampled(exp_wdata)));
	assert property (@(posedge clk) disable iff (reset)
		mem.valid == exp_mem.valid && (!exp_mem.valid || mem == exp_mem))
		else report_mismatch("mem", 128'($sampled(mem)), 128'($sampled(exp_mem)));

	function automatic xlen_t xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic xlen_t ref_alu(input logic [2:0] f3, input logic alt, input xlen_t a,
			input xlen_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic ref_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [3:0] ref_size_mask(input logic [2:0] f3);
		case (f3[1:0])
			2'd0: return 4'b0001;
			2'd1: return 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic xlen_t ref_load(input logic [2:0] f3, input xlen_t d);
		case (f3)
			3'd0: return 32'($signed(d[7:0]));
			3'd1: return 32'($signed(d[15:0]));
			3'd4: return 32'(d[7:0]);
			3'd5: return 32'(d[15:0]);
			default: return d;
		endcase
	endfunction

	// Random legal encoding of one instruction group, kind 9 gives an illegal one
	function automatic xlen_t gen_insn(input int kind);
		xlen_t      r;
		logic [2:0] f3;
		r = xorshift();
		f3 = r[14:12];
		case (kind)
			0: begin
				r[6:0] = `RV32_OP_REG;
				r[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
			end
			1: begin
				r[6:0] = `RV32_OP_IMM;
				if (f3 == 3'd1)
					r[31:25] = 7'h00;
				else if (f3 == 3'd5)
					r[31:25] = r[30] ? 7'h20 : 7'h00;
			end
			2: r[6:0] = `RV32_OP_LUI;
			3: r[6:0] = `RV32_OP_AUIPC;
			4: r[6:0] = `RV32_OP_JAL;
			5: begin
				r[6:0] = `RV32_OP_JALR;
				r[14:12] = 3'd0;
			end
			6: begin
				r[6:0] = `RV32_OP_BRANCH;
				if (f3 == 3'd2 || f3 == 3'd3)
					r[14:12] = f3 + 3'd4;
			end
			7: begin
				r[6:0] = `RV32_OP_LOAD;
				if (f3 == 3'd3)
					r[14:12] = 3'd2;
				else if (f3[2:1] == 2'b11)
					r[14:12] = f3 - 3'd2;
			end
			8: begin
				r[6:0] = `RV32_OP_STORE;
				r[14:12] = (f3 > 3'd2) ? {1'b0, f3[2:1]} - 3'd1 : f3;
			end
			default: begin
				r[6:0] = `RV32_OP_REG;   // MUL group, outside RV32I
				r[31:25] = 7'h01;
			end
		endcase
		return r;
	endfunction

	// Reference results straight from the RV32I rules
	task automatic set_expected(input xlen_t word, input xlen_t ld_data);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [4:0] rs1i;
		logic [4:0] rs2i;
		logic [4:0] rdi;
		logic       use1;
		logic       use2;
		logic       used;
		xlen_t      a;
		xlen_t      b;
		xlen_t      imm_i;
		xlen_t      imm_s;
		xlen_t      imm_b;
		xlen_t      imm_j;
		opc = word[6:0];
		f3 = word[14:12];
		rdi = word[11:7];
		rs1i = word[19:15];
		rs2i = word[24:20];
		a = (rs1i == 5'd0) ? 32'd0 : reg_vals[rs1i];
		b = (rs2i == 5'd0) ? 32'd0 : reg_vals[rs2i];
		imm_i = 32'($signed(word[31:20]));
		imm_s = 32'($signed({word[31:25], word[11:7]}));
		imm_b = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
		imm_j = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
		exp_legal = 1'b1;
		use1 = 1'b0;
		use2 = 1'b0;
		used = 1'b0;
		chk_wdata = 1'b0;
		exp_wdata = '0;
		exp_mem = '0;
		exp_next = model_pc + 32'd4;
		case (opc)
			`RV32_OP_LUI, `RV32_OP_AUIPC: begin
				used = 1'b1;
				chk_wdata = 1'b1;
				exp_wdata = {word[31:12], 12'h000};
				if (opc == `RV32_OP_AUIPC)
					exp_wdata = exp_wdata + model_pc;
			end
			`RV32_OP_JAL, `RV32_OP_JALR: begin
				used = 1'b1;
				chk_wdata = 1'b1;
				exp_wdata = model_pc + 32'd4;   // Link is the old PC plus 4
				if (opc == `RV32_OP_JAL) begin
					exp_next = model_pc + imm_j;
				end else begin
					use1 = 1'b1;
					exp_legal = (f3 == 3'd0);
					exp_next = (a + imm_i) & ~32'd1;
				end
			end
			`RV32_OP_BRANCH: begin
				use1 = 1'b1;
				use2 = 1'b1;
				exp_legal = (f3 != 3'd2) && (f3 != 3'd3);
				if (ref_taken(f3, a, b))
					exp_next = model_pc + imm_b;
			end
			`RV32_OP_LOAD: begin
				use1 = 1'b1;
				used = 1'b1;
				exp_legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
				chk_wdata = 1'b1;
				exp_wdata = ref_load(f3, ld_data);
				exp_mem.valid = 1'b1;
				exp_mem.addr = a + imm_i;
				exp_mem.rmask = ref_size_mask(f3);
			end
			`RV32_OP_STORE: begin
				use1 = 1'b1;
				use2 = 1'b1;
				exp_legal = f3 inside {3'd0, 3'd1, 3'd2};
				exp_mem.valid = 1'b1;
				exp_mem.addr = a + imm_s;
				exp_mem.wdata = b;
				exp_mem.wstrb = ref_size_mask(f3);
			end
			`RV32_OP_IMM: begin
				use1 = 1'b1;
				used = 1'b1;
				chk_wdata = 1'b1;
				if (f3 == 3'd1)
					exp_legal = (word[31:25] == 7'h00);
				else if (f3 == 3'd5)
					exp_legal = (word[31:25] == 7'h00) || (word[31:25] == 7'h20);
				exp_wdata = ref_alu(f3, (f3 == 3'd5) && word[30], a, imm_i);
			end
			`RV32_OP_REG: begin
				use1 = 1'b1;
				use2 = 1'b1;
				used = 1'b1;
				chk_wdata = 1'b1;
				exp_legal = (word[31:25] == 7'h00)
					|| (word[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				exp_wdata = ref_alu(f3, word[30], a, b);
			end
			default: exp_legal = 1'b0;
		endcase
		if (!exp_legal) begin
			use1 = 1'b0;
			use2 = 1'b0;
			used = 1'b0;
			chk_wdata = 1'b0;
			exp_mem = '0;
		end
		exp_req = {use1 && rs1i != 5'd0, use2 && rs2i != 5'd0, used && rdi != 5'd0};
		exp_addr = {rs1i, rs2i, rdi};
	endtask

	// Drives one instruction after a falling edge, may stall one ready level
	task automatic run_insn(input xlen_t word);
		int    stall;
		int    waited;
		logic  done;
		xlen_t pick;
		mem_rdata = xorshift();
		rs1_rdata = reg_vals[word[19:15]];
		rs2_rdata = reg_vals[word[24:20]];
		insn = word;
		insn_valid = 1'b1;
		set_expected(word, mem_rdata);
		pick = xorshift();
		stall = int'(pick[1:0]);
		rs1_ready = 1'b1;
		rs2_ready = 1'b1;
		rd_ready = 1'b1;
		mem_ready = 1'b1;
		if (stall != 0) begin
			case (pick[3:2])
				2'd0: rs1_ready = 1'b0;
				2'd1: rs2_ready = 1'b0;
				2'd2: rd_ready = 1'b0;
				default: mem_ready = 1'b0;
			endcase
		end
		waited = 0;
		done = 1'b0;
		while (!done && waited < 16) begin
			@(posedge clk);
			done = insn_complete;
			@(negedge clk);
			waited++;
			if (waited >= stall) begin
				rs1_ready = 1'b1;
				rs2_ready = 1'b1;
				rd_ready = 1'b1;
				mem_ready = 1'b1;
			end
		end
		if (!done) begin
			$display("timeout: instruction %h at pc %h never completed", word, model_pc);
			other_count++;
		end
		insn_count++;
	endtask

	task automatic run_trap();
		int   waited;
		logic seen;
		insn = gen_insn(9);
		insn_valid = 1'b1;
		set_expected(insn, mem_rdata);
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < 8) begin
			@(posedge clk);
			seen = trap;
			@(negedge clk);
			waited++;
		end
		if (!seen) begin
			$display("timeout: illegal instruction %h never raised trap", insn);
			other_count++;
		end
		repeat (4) @(negedge clk);   // PC must stay locked here
	endtask

	initial begin
		rng = 32'd67;
		clk = 1'b0;
		reset = 1'b1;
		insn = '0;
		insn_valid = 1'b0;
		rs1_rdata = '0;
		rs2_rdata = '0;
		rs1_ready = 1'b1;
		rs2_ready = 1'b1;
		rd_ready = 1'b1;
		mem_rdata = '0;
		mem_ready = 1'b1;
		err_count = 0;
		other_count = 0;
		insn_count = 0;
		exp_legal = 1'b1;
		exp_req = '0;
		exp_addr = '0;
		exp_mem = '0;
		exp_next = `RV32_RESET_ADDR;
		exp_wdata = '0;
		chk_wdata = 1'b0;
		for (int i = 0; i < 32; i++)
			reg_vals[i] = xorshift();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (3) @(negedge clk);   // Idle, nothing valid yet
		for (int n = 0; n < 400; n++)
			run_insn(gen_insn(int'(xorshift() % 32'd9)));
		run_trap();
		insn_valid = 1'b0;
		@(negedge clk);
		$display("checks done: %0d instructions, %0d mismatches, %0d other errors",
			insn_count, err_count, other_count);
		if (err_count == 0 && other_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+include
source/rv32_pkg.sv
source/rv32_pc_sequencer.sv
source/rv32_decode.sv
source/rv32_execute.sv
source/rv32_mem_access.sv
source/rv32_core.sv
testbench/tb_rv32_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv32_core
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
